// ==== Bender.yml ====
package:
  name: ssb_demod

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/demod_pkg.sv
      - verilog/cp_stripper.sv
      - verilog/fft_butterfly.sv
      - verilog/fft_engine.sv
      - verilog/ssb_symbol_tagger.sv
      - verilog/ssb_demod.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - test/tb_ssb_demod.sv

// ==== build.f ====
+incdir+verilog
verilog/demod_pkg.sv
verilog/cp_stripper.sv
verilog/fft_butterfly.sv
verilog/fft_engine.sv
verilog/ssb_symbol_tagger.sv
verilog/ssb_demod.sv
test/tb_ssb_demod.sv

// ==== test/tb_ssb_demod.sv ====
`include "demod_config.svh"

module tb_ssb_demod;
    timeunit 1ns;
    timeprecision 100ps;

    import demod_pkg::*;

    localparam int FFT_LEN     = `DEMOD_FFT_LEN;
    localparam int CP_LEN      = `DEMOD_CP_LEN;
    localparam int CLK_PERIOD  = 40;
    localparam int VALID_GAP   = 5;  // one valid sample every 5 cycles
    localparam int SYM_CYCLES  = (FFT_LEN + CP_LEN) * VALID_GAP;
    localparam int NUM_TESTS   = 5;
    localparam int MAX_SYMS    = 4;
    localparam int WATCHDOG_NS = (NUM_TESTS * 5 + 2) * SYM_CYCLES * CLK_PERIOD;
    localparam int IMPULSE_AMP = -(2 ** 15);  // +2^15 does not fit a signed component

    typedef struct packed {
        logic symbol_start;
        logic pbch_start;
        logic pbch_valid;
        logic sss_start;
        logic sss_valid;
    } flags_t;

    logic   clk_i;
    logic   reset_ni;
    iq_t    in_data_i;
    logic   in_valid_i;
    logic   ssb_start_i;
    iq_t    out_data_o;
    logic   out_valid_o;
    logic   symbol_start_o;
    logic   pbch_start_o;
    logic   pbch_valid_o;
    logic   sss_start_o;
    logic   sss_valid_o;

    integer seed = 31;
    int     err_count = 0;
    int     tests_failed = 0;
    iq_t    sym_buf [FFT_LEN];  // body of the next symbol to send
    iq_t    cap_data [MAX_SYMS][FFT_LEN];
    flags_t cap_flags [MAX_SYMS][FFT_LEN];
    int     cap_syms, cap_bin, valid_seen, stray_flags;

    ssb_demod ssb_demod_i (
        .clk_i          (clk_i),
        .reset_ni       (reset_ni),
        .in_data_i      (in_data_i),
        .in_valid_i     (in_valid_i),
        .ssb_start_i    (ssb_start_i),
        .out_data_o     (out_data_o),
        .out_valid_o    (out_valid_o),
        .symbol_start_o (symbol_start_o),
        .pbch_start_o   (pbch_start_o),
        .pbch_valid_o   (pbch_valid_o),
        .sss_start_o    (sss_start_o),
        .sss_valid_o    (sss_valid_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    // output collector, sampled mid cycle
    always @(negedge clk_i) begin
        if (out_valid_o === 1'b1) begin
            valid_seen++;
            if (cap_syms < MAX_SYMS) begin
                cap_data[cap_syms][cap_bin]  = out_data_o;
                cap_flags[cap_syms][cap_bin] = {symbol_start_o, pbch_start_o, pbch_valid_o,
                                                sss_start_o, sss_valid_o};
            end
            if (cap_bin == FFT_LEN - 1) begin
                cap_bin = 0;
                cap_syms++;
            end else begin
                cap_bin++;
            end
        end else if (pbch_valid_o || sss_valid_o || symbol_start_o || pbch_start_o
                     || sss_start_o) begin
            stray_flags++;  // flag without data
        end
    end

    function automatic iq_t to_iq(input int re, input int im);
        iq_t r;
        r.re = comp_t'(re);
        r.im = comp_t'(im);
        return r;
    endfunction

    function automatic iq_t rand_iq();
        iq_t r;
        r = $random(seed);
        return r;
    endfunction

    task automatic compare_iq(input string name, input iq_t got, input iq_t exp);
        if (got !== exp) begin
            $display("mismatch at %0t: %s got re %0d im %0d, expected re %0d im %0d",
                     $time, name, got.re, got.im, exp.re, exp.im);
            err_count++;
        end
    endtask

    task automatic expect_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
            err_count++;
        end
    endtask

    task automatic clear_capture();
        cap_syms    = 0;
        cap_bin     = 0;
        valid_seen  = 0;
        stray_flags = 0;
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clk_i);
            #5;
        end
    endtask

    // one valid sample, then idle until the next slot
    task automatic drive_sample(input iq_t d, input bit start);
        in_data_i   = d;
        in_valid_i  = 1'b1;
        ssb_start_i = start;
        @(posedge clk_i);
        #5;
        in_valid_i  = 1'b0;
        ssb_start_i = 1'b0;
        in_data_i   = rand_iq();  // don't care between strobes
        idle_cycles(VALID_GAP - 1);
    endtask

    task automatic feed_symbol(input bit first);
        if (!first) begin
            repeat (CP_LEN) drive_sample(rand_iq(), 1'b0);
        end
        for (int i = 0; i < FFT_LEN; i++) begin
            drive_sample(sym_buf[i], first && (i == 0));
        end
    endtask

    task automatic fill_dc(input iq_t a);
        for (int i = 0; i < FFT_LEN; i++) begin
            sym_buf[i] = a;
        end
    endtask

    task automatic wait_output(input int nsym);
        int waited;
        waited = 0;
        do begin
            @(posedge clk_i);
            waited++;
        end while ((cap_syms < nsym) && (waited < 2 * SYM_CYCLES));
        #5;
        if (cap_syms < nsym) begin
            $display("error at %0t: output symbol %0d never arrived", $time, cap_syms);
            err_count++;
        end
    endtask

    // constant input lands in bin 0 only
    task automatic inspect_dc_bins(input int sym, input iq_t a);
        if (sym < cap_syms) begin
            for (int b = 0; b < FFT_LEN; b++) begin
                compare_iq($sformatf("out_data_o sym %0d bin %0d", sym, b), cap_data[sym][b],
                           (b == 0) ? a : iq_t'('0));
            end
        end
    endtask

    // pbch on output symbol 0, sss on symbol 1, starts on bin 0
    task automatic verify_tags(input int sym);
        flags_t f;
        if (sym < cap_syms) begin
            for (int b = 0; b < FFT_LEN; b++) begin
                f = cap_flags[sym][b];
                expect_flag("symbol_start_o", f.symbol_start, b == 0);
                expect_flag("pbch_start_o", f.pbch_start, (sym == 0) && (b == 0));
                expect_flag("pbch_valid_o", f.pbch_valid, sym == 0);
                expect_flag("sss_start_o", f.sss_start, (sym == 1) && (b == 0));
                expect_flag("sss_valid_o", f.sss_valid, sym == 1);
            end
        end
    endtask

    task automatic report_test(input string name, input int err_before);
        if (err_count == err_before) begin
            $display("test %s: pass", name);
        end else begin
            $display("test %s: %0d errors", name, err_count - err_before);
            tests_failed++;
        end
    endtask

    task automatic dc_symbol();
        int  err_before;
        iq_t a;
        err_before = err_count;
        a = to_iq(1000, -500);
        clear_capture();
        fill_dc(a);
        feed_symbol(1'b1);
        wait_output(1);
        inspect_dc_bins(0, a);
        idle_cycles(20);
        report_test("dc_symbol", err_before);
    endtask

    task automatic impulse_response();
        int  err_before;
        iq_t exp;
        err_before = err_count;
        for (int i = 0; i < FFT_LEN; i++) begin
            sym_buf[i] = (i == 0) ? to_iq(IMPULSE_AMP, IMPULSE_AMP) : iq_t'('0);
        end
        exp = to_iq(IMPULSE_AMP / FFT_LEN, IMPULSE_AMP / FFT_LEN);  // flat spectrum
        clear_capture();
        feed_symbol(1'b1);
        wait_output(1);
        for (int b = 0; b < FFT_LEN && cap_syms > 0; b++) begin
            compare_iq($sformatf("out_data_o bin %0d", b), cap_data[0][b], exp);
        end
        idle_cycles(20);
        report_test("impulse_response", err_before);
    endtask

    task automatic cp_removal();
        int  err_before;
        iq_t dc [3];
        err_before = err_count;
        dc[0] = to_iq(-1200, 300);
        dc[1] = to_iq(2500, 2500);
        dc[2] = to_iq(-7, -4096);
        clear_capture();
        for (int s = 0; s < 3; s++) begin
            fill_dc(dc[s]);
            feed_symbol(s == 0);  // random cp ahead of symbols 1 and 2
        end
        wait_output(3);
        for (int s = 0; s < 3; s++) begin
            inspect_dc_bins(s, dc[s]);
        end
        idle_cycles(20);
        report_test("cp_removal", err_before);
    endtask

    task automatic symbol_tagging();
        int  err_before;
        iq_t dc [3];
        err_before = err_count;
        clear_capture();
        for (int s = 0; s < 3; s++) begin
            dc[s] = rand_iq();
            fill_dc(dc[s]);
            feed_symbol(s == 0);
        end
        wait_output(3);
        for (int s = 0; s < 3; s++) begin
            verify_tags(s);
            inspect_dc_bins(s, dc[s]);
        end
        if (stray_flags != 0) begin
            $display("error: output flags were high on %0d cycles without out_valid_o",
                     stray_flags);
            err_count++;
        end
        idle_cycles(20);
        report_test("symbol_tagging", err_before);
    endtask

    task automatic reset_mid_symbol();
        int  err_before;
        iq_t a;
        err_before = err_count;
        clear_capture();
        fill_dc(rand_iq());
        for (int i = 0; i < FFT_LEN / 2; i++) begin
            drive_sample(sym_buf[i], i == 0);
        end
        reset_ni = 1'b0;
        idle_cycles(3);
        reset_ni = 1'b1;
        // samples without an ssb start must be ignored
        for (int i = 0; i < FFT_LEN + CP_LEN; i++) begin
            drive_sample(rand_iq(), 1'b0);
        end
        idle_cycles(SYM_CYCLES);  // room for a stray symbol to get through the fft
        if (valid_seen != 0) begin
            $display("error: output went valid after reset before a new ssb start");
            err_count++;
        end
        a = to_iq(-3333, 1234);
        clear_capture();
        fill_dc(a);
        feed_symbol(1'b1);
        wait_output(1);
        inspect_dc_bins(0, a);
        verify_tags(0);
        idle_cycles(20);
        report_test("reset_mid_symbol", err_before);
    endtask

    initial begin
        reset_ni    = 1'b0;
        in_data_i   = '0;
        in_valid_i  = 1'b0;
        ssb_start_i = 1'b0;
        clear_capture();
        repeat (3) @(posedge clk_i);
        #5;
        reset_ni = 1'b1;
        idle_cycles(2);

        dc_symbol();
        impulse_response();
        cp_removal();
        symbol_tagging();
        reset_mid_symbol();

        $display("tests run %0d, tests failed %0d, errors %0d",
                 NUM_TESTS, tests_failed, err_count);
        if (err_count == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

    // five symbol periods per test plus two spare
    initial begin
        #(WATCHDOG_NS);
        $display("error: watchdog expired, the run timed out");
        $display("TB FAILED");
        $finish;
    end

endmodule

// ==== verilog/cp_stripper.sv ====
`include "demod_config.svh"

module cp_stripper (
    input  logic                   clk_i,
    input  logic                   reset_ni,
    input  demod_pkg::iq_t         in_data_i,
    input  logic                   in_valid_i,
    input  logic                   ssb_start_i,
    output demod_pkg::sample_wr_t  wr_o,
    output logic                   wr_valid_o
);
    import demod_pkg::*;

    localparam int FFT_LEN = `DEMOD_FFT_LEN;
    localparam int CP_LEN  = `DEMOD_CP_LEN;
    localparam int CP_W    = $clog2(CP_LEN);

    strip_state_t    state;
    logic [CP_W-1:0] cp_cnt;
    bin_idx_t        samp_idx;  // position of the next kept sample
    bin_idx_t        cur_idx;
    logic            take;

    // ssb_start_i comes with sample 0 of the first symbol, whose cp is gone
    assign take    = in_valid_i && (ssb_start_i || (state == TAKE));
    assign cur_idx = ssb_start_i ? '0 : samp_idx;

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            state    <= IDLE;
            cp_cnt   <= '0;
            samp_idx <= '0;
        end else if (ssb_start_i) begin
            state    <= TAKE;  // restart on every ssb
            cp_cnt   <= '0;
            samp_idx <= bin_idx_t'(in_valid_i);
        end else begin
            case (state)
                IDLE: begin
                    cp_cnt <= '0;
                end
                SKIP_CP: begin
                    if (in_valid_i) begin
                        if (cp_cnt == CP_W'(CP_LEN - 1)) begin
                            cp_cnt <= '0;
                            state  <= TAKE;
                        end else begin
                            cp_cnt <= cp_cnt + 1'b1;
                        end
                    end
                end
                TAKE: begin
                    if (in_valid_i) begin
                        samp_idx <= samp_idx + 1'b1;  // wraps to 0 after the last
                        if (samp_idx == bin_idx_t'(FFT_LEN - 1)) begin
                            state <= SKIP_CP;
                        end
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            wr_valid_o <= 1'b0;
        end else begin
            wr_valid_o <= take;
        end
    end

    // registered sample stamped with its index
    always_ff @(posedge clk_i) begin
        wr_o.data <= in_data_i;
        wr_o.idx  <= cur_idx;
        wr_o.last <= (cur_idx == bin_idx_t'(FFT_LEN - 1));
    end

endmodule

// ==== verilog/demod_config.svh ====
`ifndef DEMOD_CONFIG_SVH
`define DEMOD_CONFIG_SVH

// FFT size as log2 and as a sample count
`define DEMOD_NFFT    8
`define DEMOD_FFT_LEN (1 << `DEMOD_NFFT)

// cyclic prefix of every symbol after the first
`define DEMOD_CP_LEN  18

`define DEMOD_IQ_W    16  // bits per I or Q component
`define DEMOD_TWDL_W  18  // twiddle component, unity = 2**(w-2)

`endif

// ==== verilog/demod_pkg.sv ====
`include "demod_config.svh"

package demod_pkg;

    typedef logic signed [`DEMOD_IQ_W-1:0]   comp_t;  // one I or Q component
    typedef logic signed [`DEMOD_TWDL_W-1:0] twdl_t;  // one twiddle component

    // im in the upper half, re in the lower half
    typedef struct packed {
        comp_t im;
        comp_t re;
    } iq_t;

    typedef logic [`DEMOD_NFFT-1:0] bin_idx_t;  // sample or bin inside a symbol
    typedef logic [1:0]             symbol_cnt_t;  // saturates at 2

    // one kept sample on its way into the fill bank
    typedef struct packed {
        iq_t      data;
        bin_idx_t idx;
        logic     last;
    } sample_wr_t;

    typedef enum logic [1:0] {
        IDLE,
        SKIP_CP,
        TAKE
    } strip_state_t;

    typedef enum logic [1:0] {
        FILL,
        COMPUTE,
        DRAIN
    } fft_state_t;

    typedef enum logic [1:0] {
        WAIT_SSB,
        WAIT_SYM,
        OUT_SYM
    } tag_state_t;

endpackage

// ==== verilog/fft_butterfly.sv ====
`include "demod_config.svh"

module fft_butterfly (
    input  logic             clk_i,
    input  logic             reset_ni,
    input  logic             go_i,
    input  demod_pkg::iq_t   a_i,
    input  demod_pkg::iq_t   b_i,
    input  demod_pkg::twdl_t tw_re_i,
    input  demod_pkg::twdl_t tw_im_i,
    output demod_pkg::iq_t   sum_o,
    output demod_pkg::iq_t   diff_o,
    output logic             done_o
);
    import demod_pkg::*;

    localparam int W  = `DEMOD_IQ_W;
    localparam int TW = `DEMOD_TWDL_W;
    localparam int PW = W + TW + 2;  // product plus one bit for the add

    logic signed [W:0]    s1_sum_re, s1_sum_im;
    logic signed [W:0]    s1_dif_re, s1_dif_im;
    twdl_t                s1_tw_re, s1_tw_im;
    logic signed [W:0]    s2_sum_re, s2_sum_im;
    logic signed [PW-1:0] s2_prd_re, s2_prd_im;
    logic [2:0]           vld;

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            vld <= '0;
        end else begin
            vld <= {vld[1:0], go_i};
        end
    end

    always_ff @(posedge clk_i) begin
        // stage 1, full precision add and subtract
        s1_sum_re <= a_i.re + b_i.re;
        s1_sum_im <= a_i.im + b_i.im;
        s1_dif_re <= a_i.re - b_i.re;
        s1_dif_im <= a_i.im - b_i.im;
        s1_tw_re  <= tw_re_i;
        s1_tw_im  <= tw_im_i;

        // stage 2, (a - b) * w
        s2_prd_re <= s1_dif_re * s1_tw_re - s1_dif_im * s1_tw_im;
        s2_prd_im <= s1_dif_re * s1_tw_im + s1_dif_im * s1_tw_re;
        s2_sum_re <= s1_sum_re;
        s2_sum_im <= s1_sum_im;

        // stage 3, drop twiddle scale and halve, plain truncation
        sum_o.re  <= s2_sum_re[W:1];
        sum_o.im  <= s2_sum_im[W:1];
        diff_o.re <= s2_prd_re[TW-1 +: W];
        diff_o.im <= s2_prd_im[TW-1 +: W];
    end

    assign done_o = vld[2];

endmodule

// ==== verilog/fft_engine.sv ====
`include "demod_config.svh"

module fft_engine (
    input  logic                  clk_i,
    input  logic                  reset_ni,
    input  demod_pkg::sample_wr_t wr_i,
    input  logic                  wr_valid_i,
    output demod_pkg::iq_t        fft_data_o,
    output logic                  fft_valid_o,
    output logic                  fft_sync_o
);
    import demod_pkg::*;

    localparam int  NFFT    = `DEMOD_NFFT;
    localparam int  FFT_LEN = `DEMOD_FFT_LEN;
    localparam int  TW      = `DEMOD_TWDL_W;
    localparam int  TWI_W   = NFFT - 1;  // butterfly and twiddle index
    localparam int  STG_W   = $clog2(NFFT);
    localparam real PI      = 3.14159265358979323846;
    localparam real UNITY   = 2.0 ** (TW - 2);

    // w(n) = exp(-j*2*pi*n/N) for the first half circle
    function automatic logic [FFT_LEN/2-1:0][TW-1:0] make_twiddles(input bit want_sin);
        logic [FFT_LEN/2-1:0][TW-1:0] tab;
        real                          ang;
        tab = '0;
        for (int n = 0; n < FFT_LEN / 2; n++) begin
            ang = 2.0 * PI * n / FFT_LEN;
            if (want_sin) begin
                tab[n] = TW'(int'(-UNITY * $sin(ang)));
            end else begin
                tab[n] = TW'(int'(UNITY * $cos(ang)));
            end
        end
        return tab;
    endfunction

    function automatic bin_idx_t bit_rev(input bin_idx_t v);
        bin_idx_t r;
        for (int i = 0; i < NFFT; i++) begin
            r[i] = v[NFFT-1-i];
        end
        return r;
    endfunction

    localparam logic [FFT_LEN/2-1:0][TW-1:0] TW_COS  = make_twiddles(1'b0);
    localparam logic [FFT_LEN/2-1:0][TW-1:0] TW_NSIN = make_twiddles(1'b1);

    iq_t              mem [2][FFT_LEN];
    logic             fill_bank;  // bank taking writes, the other one is computed
    logic             cbank;
    fft_state_t       state;
    logic [STG_W-1:0] stage;
    logic [TWI_W-1:0] bf_cnt;
    logic             bf_run;  // low during the gap after a stage
    logic [1:0]       gap_cnt;
    bin_idx_t         out_cnt;

    bin_idx_t         span, mask, k_ext, rd_a, rd_b;
    logic [TWI_W-1:0] tw_idx;
    bin_idx_t [2:0]   wb_a_q, wb_b_q;  // write-back addresses, 3 deep
    iq_t              bf_a, bf_b, bf_sum, bf_diff;
    twdl_t            bf_tw_re, bf_tw_im;
    logic             bf_go, bf_done;

    assign cbank = ~fill_bank;

    // dif pair: insert a zero at the span bit of the butterfly count
    always_comb begin
        span   = bin_idx_t'(FFT_LEN / 2) >> stage;
        mask   = span - 1'b1;
        k_ext  = {1'b0, bf_cnt};
        rd_a   = (k_ext & mask) | ((k_ext & ~mask) << 1);
        rd_b   = rd_a | span;
        tw_idx = TWI_W'((k_ext & mask) << stage);
    end

    assign bf_a     = mem[cbank][rd_a];
    assign bf_b     = mem[cbank][rd_b];
    assign bf_tw_re = twdl_t'(TW_COS[tw_idx]);
    assign bf_tw_im = twdl_t'(TW_NSIN[tw_idx]);
    assign bf_go    = (state == COMPUTE) && bf_run;

    fft_butterfly bfly_i (
        .clk_i    (clk_i),
        .reset_ni (reset_ni),
        .go_i     (bf_go),
        .a_i      (bf_a),
        .b_i      (bf_b),
        .tw_re_i  (bf_tw_re),
        .tw_im_i  (bf_tw_im),
        .sum_o    (bf_sum),
        .diff_o   (bf_diff),
        .done_o   (bf_done)
    );

    always_ff @(posedge clk_i) begin
        wb_a_q <= {wb_a_q[1:0], rd_a};
        wb_b_q <= {wb_b_q[1:0], rd_b};
    end

    // fill writes and in-place results never hit the same bank
    always_ff @(posedge clk_i) begin
        if (wr_valid_i) begin
            mem[fill_bank][wr_i.idx] <= wr_i.data;
        end
        if (bf_done) begin
            mem[cbank][wb_a_q[2]] <= bf_sum;
            mem[cbank][wb_b_q[2]] <= bf_diff;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            state     <= FILL;
            fill_bank <= 1'b0;
            stage     <= '0;
            bf_cnt    <= '0;
            bf_run    <= 1'b0;
            gap_cnt   <= '0;
            out_cnt   <= '0;
        end else begin
            case (state)
                FILL: begin
                    if (wr_valid_i && wr_i.last) begin
                        fill_bank <= ~fill_bank;  // full bank goes to compute
                        state     <= COMPUTE;
                        stage     <= '0;
                        bf_cnt    <= '0;
                        bf_run    <= 1'b1;
                    end
                end
                COMPUTE: begin
                    if (bf_run) begin
                        bf_cnt <= bf_cnt + 1'b1;
                        if (&bf_cnt) begin
                            bf_run  <= 1'b0;
                            gap_cnt <= '0;
                        end
                    end else begin
                        // wait out the butterfly pipeline before the next stage
                        gap_cnt <= gap_cnt + 1'b1;
                        if (gap_cnt == 2'd2) begin
                            if (stage == STG_W'(NFFT - 1)) begin
                                state   <= DRAIN;
                                out_cnt <= '0;
                            end else begin
                                stage  <= stage + 1'b1;
                                bf_run <= 1'b1;
                            end
                        end
                    end
                end
                DRAIN: begin
                    out_cnt <= out_cnt + 1'b1;
                    if (&out_cnt) begin
                        state <= FILL;
                    end
                end
                default: state <= FILL;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            fft_valid_o <= 1'b0;
            fft_sync_o  <= 1'b0;
        end else begin
            fft_valid_o <= (state == DRAIN);
            fft_sync_o  <= (state == DRAIN) && (out_cnt == '0);
        end
    end

    // dif leaves bins bit reversed
    always_ff @(posedge clk_i) begin
        fft_data_o <= mem[cbank][bit_rev(out_cnt)];
    end

endmodule

// ==== verilog/ssb_demod.sv ====
module ssb_demod (
    input  logic           clk_i,
    input  logic           reset_ni,
    input  demod_pkg::iq_t in_data_i,
    input  logic           in_valid_i,
    input  logic           ssb_start_i,
    output demod_pkg::iq_t out_data_o,
    output logic           out_valid_o,
    output logic           symbol_start_o,
    output logic           pbch_start_o,
    output logic           pbch_valid_o,
    output logic           sss_start_o,
    output logic           sss_valid_o
);
    import demod_pkg::*;

    sample_wr_t wr;
    logic       wr_valid;
    iq_t        fft_data;
    logic       fft_valid;
    logic       fft_sync;

    cp_stripper cp_stripper_i (
        .clk_i       (clk_i),
        .reset_ni    (reset_ni),
        .in_data_i   (in_data_i),
        .in_valid_i  (in_valid_i),
        .ssb_start_i (ssb_start_i),
        .wr_o        (wr),
        .wr_valid_o  (wr_valid)
    );

    fft_engine fft_engine_i (
        .clk_i       (clk_i),
        .reset_ni    (reset_ni),
        .wr_i        (wr),
        .wr_valid_i  (wr_valid),
        .fft_data_o  (fft_data),
        .fft_valid_o (fft_valid),
        .fft_sync_o  (fft_sync)
    );

    // the tagger also sees ssb start to restart its symbol count
    ssb_symbol_tagger ssb_symbol_tagger_i (
        .clk_i          (clk_i),
        .reset_ni       (reset_ni),
        .ssb_start_i    (ssb_start_i),
        .fft_data_i     (fft_data),
        .fft_valid_i    (fft_valid),
        .fft_sync_i     (fft_sync),
        .out_data_o     (out_data_o),
        .out_valid_o    (out_valid_o),
        .symbol_start_o (symbol_start_o),
        .pbch_start_o   (pbch_start_o),
        .pbch_valid_o   (pbch_valid_o),
        .sss_start_o    (sss_start_o),
        .sss_valid_o    (sss_valid_o)
    );

endmodule

// ==== verilog/ssb_symbol_tagger.sv ====
module ssb_symbol_tagger (
    input  logic           clk_i,
    input  logic           reset_ni,
    input  logic           ssb_start_i,
    input  demod_pkg::iq_t fft_data_i,
    input  logic           fft_valid_i,
    input  logic           fft_sync_i,
    output demod_pkg::iq_t out_data_o,
    output logic           out_valid_o,
    output logic           symbol_start_o,
    output logic           pbch_start_o,
    output logic           pbch_valid_o,
    output logic           sss_start_o,
    output logic           sss_valid_o
);
    import demod_pkg::*;

    tag_state_t  state;
    bin_idx_t    bin_cnt;
    symbol_cnt_t sym_cnt;  // output symbols since ssb start
    logic        first_bin;
    logic        in_sym;

    assign first_bin = fft_valid_i && fft_sync_i && (state == WAIT_SYM);
    assign in_sym    = first_bin || (fft_valid_i && (state == OUT_SYM));

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            state   <= WAIT_SSB;
            bin_cnt <= '0;
            sym_cnt <= '0;
        end else if (ssb_start_i) begin
            state   <= WAIT_SYM;
            bin_cnt <= '0;
            sym_cnt <= '0;
        end else begin
            case (state)
                WAIT_SSB: begin
                    bin_cnt <= '0;
                end
                WAIT_SYM: begin
                    if (first_bin) begin
                        state   <= OUT_SYM;
                        bin_cnt <= bin_idx_t'(1);
                    end
                end
                OUT_SYM: begin
                    if (fft_valid_i) begin
                        bin_cnt <= bin_cnt + 1'b1;
                        if (&bin_cnt) begin
                            state <= WAIT_SYM;
                            if (sym_cnt != 2'd2) begin
                                sym_cnt <= sym_cnt + 1'b1;  // stops at 2
                            end
                        end
                    end
                end
                default: state <= WAIT_SSB;
            endcase
        end
    end

    // flags line up with the registered data
    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            out_valid_o    <= 1'b0;
            symbol_start_o <= 1'b0;
            pbch_start_o   <= 1'b0;
            pbch_valid_o   <= 1'b0;
            sss_start_o    <= 1'b0;
            sss_valid_o    <= 1'b0;
        end else begin
            out_valid_o    <= fft_valid_i;
            symbol_start_o <= fft_valid_i && fft_sync_i;
            pbch_start_o   <= first_bin && (sym_cnt == 2'd0);
            pbch_valid_o   <= in_sym && (sym_cnt == 2'd0);
            sss_start_o    <= first_bin && (sym_cnt == 2'd1);
            sss_valid_o    <= in_sym && (sym_cnt == 2'd1);
        end
    end

    always_ff @(posedge clk_i) begin
        out_data_o <= fft_data_i;
    end

endmodule
